// File: logic/fir_pkg.sv
`default_nettype none

package fir_pkg;

	// axi bus geometry
	localparam int axi_data_width = 32;
	localparam int axi_addr_width = 16;
	// byte offset inside a 32-bit word
	localparam int addr_lsb = 2;
	localparam int word_addr_width = axi_addr_width - addr_lsb;

	// word address split for coefficient writes
	localparam int slot_width = 7;
	localparam int bank_width = 7;

	// one word address, seen either flat or as bank and slot
	typedef union packed {
		logic [word_addr_width-1:0] index;
		struct packed {
			logic [bank_width-1:0] bank;
			logic [slot_width-1:0] slot;
		} coef;
	} reg_addr_u;

	// bank 1 holds the coefficients, slot is the tap number
	localparam logic [bank_width-1:0] coef_bank = 1;

	// control registers, bank 0
	localparam logic [word_addr_width-1:0] reg_name = 0;
	localparam logic [word_addr_width-1:0] reg_version = 1;
	localparam logic [word_addr_width-1:0] reg_taps = 4;
	localparam logic [word_addr_width-1:0] reg_coef_mag = 12;
	localparam logic [word_addr_width-1:0] reg_coef_base = 16;
	localparam logic [word_addr_width-1:0] reg_switches = 20;

	// identification words, ascii stored back to front
	localparam logic [axi_data_width-1:0] prog_name = "_RIF";
	localparam logic [axi_data_width-1:0] prog_version = "0.2";

	// switches register bits
	localparam int sw_fir_enable = 1;

	// edges from fir_in to fir_out
	localparam int fir_latency = 3;

endpackage

`default_nettype wire

// File: logic/reg_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface reg_bus_if;
	import fir_pkg::*;

	// write strobe with word address and data
	logic wr_en;
	reg_addr_u wr_addr;
	logic [axi_data_width-1:0] wr_data;
	// read strobe, data comes back combinationally
	logic rd_en;
	reg_addr_u rd_addr;
	logic [axi_data_width-1:0] rd_data;

	modport slave_side (
		output wr_en, wr_addr, wr_data, rd_en, rd_addr,
		input rd_data
	);

	// register block ignores rd_en, reads have no side effects
	modport regs_side (
		input wr_en, wr_addr, wr_data, rd_addr,
		output rd_data
	);

endinterface

`default_nettype wire

// File: logic/axi_lite_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_slave (
	input wire logic S_AXI_ACLK,
	input wire logic S_AXI_ARESETN,
	// write address channel
	input wire logic [fir_pkg::axi_addr_width-1:0] S_AXI_AWADDR,
	input wire logic [2:0] S_AXI_AWPROT,
	input wire logic S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	// write data channel
	input wire logic [fir_pkg::axi_data_width-1:0] S_AXI_WDATA,
	input wire logic [fir_pkg::axi_data_width/8-1:0] S_AXI_WSTRB,
	input wire logic S_AXI_WVALID,
	output logic S_AXI_WREADY,
	// write response channel
	output logic [1:0] S_AXI_BRESP,
	output logic S_AXI_BVALID,
	input wire logic S_AXI_BREADY,
	// read address channel
	input wire logic [fir_pkg::axi_addr_width-1:0] S_AXI_ARADDR,
	input wire logic [2:0] S_AXI_ARPROT,
	input wire logic S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	// read data channel
	output logic [fir_pkg::axi_data_width-1:0] S_AXI_RDATA,
	output logic [1:0] S_AXI_RRESP,
	output logic S_AXI_RVALID,
	input wire logic S_AXI_RREADY,
	// register side
	reg_bus_if.slave_side bus
);
	import fir_pkg::*;

	localparam logic [1:0] resp_okay = 2'b00;

	// high while no write is between acceptance and its response
	logic wr_idle;
	logic wr_start;
	logic rd_start;
	reg_addr_u wr_addr_q;
	logic [axi_data_width-1:0] wr_data_q;
	reg_addr_u rd_addr_q;

	// address and data taken in the same cycle
	assign wr_start = wr_idle && S_AXI_AWVALID && S_AXI_WVALID;
	// no new read while the last one still waits for RREADY
	assign rd_start = !S_AXI_ARREADY && S_AXI_ARVALID && !S_AXI_RVALID;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			S_AXI_AWREADY <= 1'b0;
			S_AXI_WREADY <= 1'b0;
			wr_idle <= 1'b1;
		end else begin
			if (wr_start) begin
				// both readies pulse together
				S_AXI_AWREADY <= 1'b1;
				S_AXI_WREADY <= 1'b1;
				wr_idle <= 1'b0;
			end else begin
				S_AXI_AWREADY <= 1'b0;
				S_AXI_WREADY <= 1'b0;
				// reopen only once the response is taken
				if (S_AXI_BVALID && S_AXI_BREADY) begin
					wr_idle <= 1'b1;
				end
			end
		end
	end

	// latch address without byte offset, and data
	always_ff @(posedge S_AXI_ACLK) begin
		if (wr_start) begin
			wr_addr_q <= reg_addr_u'(S_AXI_AWADDR[axi_addr_width-1:addr_lsb]);
			wr_data_q <= S_AXI_WDATA;
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			S_AXI_BVALID <= 1'b0;
		end else begin
			if (bus.wr_en) begin
				S_AXI_BVALID <= 1'b1;
			end else if (S_AXI_BREADY) begin
				S_AXI_BVALID <= 1'b0;
			end
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			S_AXI_ARREADY <= 1'b0;
			S_AXI_RVALID <= 1'b0;
		end else begin
			S_AXI_ARREADY <= rd_start;
			if (bus.rd_en) begin
				S_AXI_RVALID <= 1'b1;
			end else if (S_AXI_RREADY) begin
				S_AXI_RVALID <= 1'b0;
			end
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (rd_start) begin
			rd_addr_q <= reg_addr_u'(S_AXI_ARADDR[axi_addr_width-1:addr_lsb]);
		end
	end

	// read data held until the next read strobe
	always_ff @(posedge S_AXI_ACLK) begin
		if (bus.rd_en) begin
			S_AXI_RDATA <= bus.rd_data;
		end
	end

	// one strobe per transaction, in the ready cycle
	assign bus.wr_en = S_AXI_AWREADY && S_AXI_WREADY;
	assign bus.wr_addr = wr_addr_q;
	assign bus.wr_data = wr_data_q;
	assign bus.rd_en = S_AXI_ARREADY && S_AXI_ARVALID;
	assign bus.rd_addr = rd_addr_q;

	// every access answers OKAY
	assign S_AXI_BRESP = resp_okay;
	assign S_AXI_RRESP = resp_okay;

endmodule

`default_nettype wire

// File: logic/fir_regs.sv
`timescale 1ns/1ps
`default_nettype none

module fir_regs #(
	parameter int TAPS = 8,
	parameter int COEF_WIDTH = 18,
	parameter int COEF_MAG = 17
) (
	input wire logic S_AXI_ACLK,
	input wire logic S_AXI_ARESETN,
	reg_bus_if.regs_side bus,
	output logic fir_enable,
	output logic [7:0] leds,
	// coefficient write port
	output logic coef_wr,
	output logic [fir_pkg::slot_width-1:0] coef_idx,
	output logic signed [COEF_WIDTH-1:0] coef_val
);
	import fir_pkg::*;

	logic [axi_data_width-1:0] switches;
	logic coef_hit;

	// bank and slot view, slot must name an existing tap
	assign coef_hit = (bus.wr_addr.coef.bank == coef_bank) && (bus.wr_addr.coef.slot < TAPS);

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			switches <= '0;
		end else begin
			if (bus.wr_en && (bus.wr_addr.index == reg_switches)) begin
				switches <= bus.wr_data;
			end
		end
	end

	// one-cycle strobe to the datapath
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			coef_wr <= 1'b0;
		end else begin
			coef_wr <= bus.wr_en && coef_hit;
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (bus.wr_en && coef_hit) begin
			coef_idx <= bus.wr_addr.coef.slot;
			// bit 31 is the sign, low bits the magnitude field
			coef_val <= {bus.wr_data[axi_data_width-1], bus.wr_data[COEF_WIDTH-2:0]};
		end
	end

	// flat view for the control registers
	always_comb begin
		case (bus.rd_addr.index)
			reg_name: bus.rd_data = prog_name;
			reg_version: bus.rd_data = prog_version;
			reg_taps: bus.rd_data = axi_data_width'(TAPS);
			reg_coef_mag: bus.rd_data = axi_data_width'(COEF_MAG);
			reg_coef_base: bus.rd_data = axi_data_width'(coef_bank);
			reg_switches: bus.rd_data = switches;
			// coefficients are write only, unmapped reads as zero
			default: bus.rd_data = '0;
		endcase
	end

	assign leds = switches[7:0];
	assign fir_enable = switches[sw_fir_enable];

endmodule

`default_nettype wire

// File: logic/fir_tap.sv
`timescale 1ns/1ps
`default_nettype none

module fir_tap #(
	parameter int DATA_WIDTH = 14,
	parameter int COEF_WIDTH = 18,
	parameter int SUM_WIDTH = 35
) (
	input wire logic S_AXI_ACLK,
	input wire logic S_AXI_ARESETN,
	input wire logic load,
	input wire logic signed [COEF_WIDTH-1:0] coef_in,
	input wire logic signed [DATA_WIDTH-1:0] sample,
	input wire logic signed [SUM_WIDTH-1:0] sum_in,
	output logic signed [SUM_WIDTH-1:0] sum_out
);

	logic signed [COEF_WIDTH-1:0] coef_q;
	logic signed [DATA_WIDTH+COEF_WIDTH-1:0] product;

	// coefficient starts at zero, so the tap adds nothing until loaded
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			coef_q <= '0;
		end else if (load) begin
			coef_q <= coef_in;
		end
	end

	// full-width signed product
	assign product = sample * coef_q;

	// transposed form, partial sum moves one tap per clock
	always_ff @(posedge S_AXI_ACLK) begin
		sum_out <= sum_in + product;
	end

endmodule

`default_nettype wire

// File: logic/fir_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module fir_datapath #(
	parameter int TAPS = 8,
	parameter int DATA_WIDTH = 14,
	parameter int COEF_WIDTH = 18,
	parameter int COEF_MAG = 17
) (
	input wire logic S_AXI_ACLK,
	input wire logic S_AXI_ARESETN,
	input wire logic signed [DATA_WIDTH-1:0] fir_in,
	input wire logic fir_enable,
	input wire logic coef_wr,
	input wire logic [fir_pkg::slot_width-1:0] coef_idx,
	input wire logic signed [COEF_WIDTH-1:0] coef_val,
	output logic signed [DATA_WIDTH-1:0] fir_out
);
	import fir_pkg::*;

	// room for TAPS full products, no overflow
	localparam int sum_width = DATA_WIDTH + COEF_WIDTH + $clog2(TAPS);
	// input and output registers take two of the latency edges
	localparam int byp_depth = fir_latency - 2;

	logic signed [DATA_WIDTH-1:0] x_q;
	logic signed [DATA_WIDTH-1:0] byp_q [byp_depth];
	logic signed [sum_width-1:0] tap_sum [TAPS+1];
	logic signed [sum_width-1:0] sum_shifted;
	logic signed [DATA_WIDTH-1:0] filtered;
	logic [TAPS-1:0] tap_load;

	// input register, broadcast to all taps
	always_ff @(posedge S_AXI_ACLK) begin
		x_q <= fir_in;
	end

	// chain is fed with zero at the far end
	assign tap_sum[TAPS] = '0;

	for (genvar k = 0; k < TAPS; k++) begin : g_tap
		// slot number selects the tap
		assign tap_load[k] = coef_wr && (coef_idx == slot_width'(k));

		fir_tap #(
			.DATA_WIDTH(DATA_WIDTH),
			.COEF_WIDTH(COEF_WIDTH),
			.SUM_WIDTH(sum_width)
		) fir_tap_i (
			.S_AXI_ACLK(S_AXI_ACLK),
			.S_AXI_ARESETN(S_AXI_ARESETN),
			.load(tap_load[k]),
			.coef_in(coef_val),
			.sample(x_q),
			.sum_in(tap_sum[k+1]),
			.sum_out(tap_sum[k])
		);
	end

	// tap 0 holds the whole sum
	assign sum_shifted = tap_sum[0] >>> COEF_MAG;
	// low bits only, wraps on overflow
	assign filtered = sum_shifted[DATA_WIDTH-1:0];

	// bypass delay lines up with the tap stage
	always_ff @(posedge S_AXI_ACLK) begin
		byp_q[0] <= x_q;
		for (int i = 1; i < byp_depth; i++) begin
			byp_q[i] <= byp_q[i-1];
		end
	end

	// output register, same latency in both modes
	always_ff @(posedge S_AXI_ACLK) begin
		fir_out <= fir_enable ? filtered : byp_q[byp_depth-1];
	end

endmodule

`default_nettype wire

// File: logic/fir_axi_top.sv
`timescale 1ns/1ps
`default_nettype none

module fir_axi_top #(
	parameter int TAPS = 8,
	parameter int DATA_WIDTH = 14,
	parameter int COEF_WIDTH = 18,
	parameter int COEF_MAG = 17
) (
	input wire logic S_AXI_ACLK,
	input wire logic S_AXI_ARESETN,
	input wire logic [fir_pkg::axi_addr_width-1:0] S_AXI_AWADDR,
	input wire logic [2:0] S_AXI_AWPROT,
	input wire logic S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	input wire logic [fir_pkg::axi_data_width-1:0] S_AXI_WDATA,
	input wire logic [fir_pkg::axi_data_width/8-1:0] S_AXI_WSTRB,
	input wire logic S_AXI_WVALID,
	output logic S_AXI_WREADY,
	output logic [1:0] S_AXI_BRESP,
	output logic S_AXI_BVALID,
	input wire logic S_AXI_BREADY,
	input wire logic [fir_pkg::axi_addr_width-1:0] S_AXI_ARADDR,
	input wire logic [2:0] S_AXI_ARPROT,
	input wire logic S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	output logic [fir_pkg::axi_data_width-1:0] S_AXI_RDATA,
	output logic [1:0] S_AXI_RRESP,
	output logic S_AXI_RVALID,
	input wire logic S_AXI_RREADY,
	// sample path, one sample per clock
	input wire logic signed [DATA_WIDTH-1:0] fir_in,
	output logic signed [DATA_WIDTH-1:0] fir_out,
	output logic [7:0] leds
);
	import fir_pkg::*;

	logic fir_enable;
	logic coef_wr;
	logic [slot_width-1:0] coef_idx;
	logic signed [COEF_WIDTH-1:0] coef_val;

	reg_bus_if reg_bus ();

	axi_lite_slave axi_lite_slave_i (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.S_AXI_AWADDR(S_AXI_AWADDR),
		.S_AXI_AWPROT(S_AXI_AWPROT),
		.S_AXI_AWVALID(S_AXI_AWVALID),
		.S_AXI_AWREADY(S_AXI_AWREADY),
		.S_AXI_WDATA(S_AXI_WDATA),
		.S_AXI_WSTRB(S_AXI_WSTRB),
		.S_AXI_WVALID(S_AXI_WVALID),
		.S_AXI_WREADY(S_AXI_WREADY),
		.S_AXI_BRESP(S_AXI_BRESP),
		.S_AXI_BVALID(S_AXI_BVALID),
		.S_AXI_BREADY(S_AXI_BREADY),
		.S_AXI_ARADDR(S_AXI_ARADDR),
		.S_AXI_ARPROT(S_AXI_ARPROT),
		.S_AXI_ARVALID(S_AXI_ARVALID),
		.S_AXI_ARREADY(S_AXI_ARREADY),
		.S_AXI_RDATA(S_AXI_RDATA),
		.S_AXI_RRESP(S_AXI_RRESP),
		.S_AXI_RVALID(S_AXI_RVALID),
		.S_AXI_RREADY(S_AXI_RREADY),
		.bus(reg_bus.slave_side)
	);

	// switches, id words and coefficient decode
	fir_regs #(
		.TAPS(TAPS),
		.COEF_WIDTH(COEF_WIDTH),
		.COEF_MAG(COEF_MAG)
	) fir_regs_i (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.bus(reg_bus.regs_side),
		.fir_enable(fir_enable),
		.leds(leds),
		.coef_wr(coef_wr),
		.coef_idx(coef_idx),
		.coef_val(coef_val)
	);

	fir_datapath #(
		.TAPS(TAPS),
		.DATA_WIDTH(DATA_WIDTH),
		.COEF_WIDTH(COEF_WIDTH),
		.COEF_MAG(COEF_MAG)
	) fir_datapath_i (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.fir_in(fir_in),
		.fir_enable(fir_enable),
		.coef_wr(coef_wr),
		.coef_idx(coef_idx),
		.coef_val(coef_val),
		.fir_out(fir_out)
	);

endmodule

`default_nettype wire

// File: tb/fir_axi_top_properties.sv
`timescale 1ns/1ps
`default_nettype none

module fir_axi_top_properties (
	input wire logic S_AXI_ACLK,
	input wire logic S_AXI_ARESETN,
	input wire logic S_AXI_AWREADY,
	input wire logic [1:0] S_AXI_BRESP,
	input wire logic S_AXI_BVALID,
	input wire logic S_AXI_BREADY,
	input wire logic [31:0] S_AXI_RDATA,
	input wire logic [1:0] S_AXI_RRESP,
	input wire logic S_AXI_RVALID,
	input wire logic S_AXI_RREADY
);

	int fail_count = 0;

	// response held until taken
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID)
		else begin
			$error("BVALID dropped before BREADY");
			fail_count++;
		end

	// read data frozen while waiting
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA))
		else begin
			$error("RVALID or RDATA changed before RREADY");
			fail_count++;
		end

	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_BVALID |-> S_AXI_BRESP == 2'b00)
		else begin
			$error("BRESP not OKAY");
			fail_count++;
		end

	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_RVALID |-> S_AXI_RRESP == 2'b00)
		else begin
			$error("RRESP not OKAY");
			fail_count++;
		end

	// single outstanding write
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_BVALID |-> !S_AXI_AWREADY)
		else begin
			$error("AWREADY while a response is pending");
			fail_count++;
		end

endmodule

bind fir_axi_top fir_axi_top_properties fir_axi_top_properties_i (
	.S_AXI_ACLK(S_AXI_ACLK),
	.S_AXI_ARESETN(S_AXI_ARESETN),
	.S_AXI_AWREADY(S_AXI_AWREADY),
	.S_AXI_BRESP(S_AXI_BRESP),
	.S_AXI_BVALID(S_AXI_BVALID),
	.S_AXI_BREADY(S_AXI_BREADY),
	.S_AXI_RDATA(S_AXI_RDATA),
	.S_AXI_RRESP(S_AXI_RRESP),
	.S_AXI_RVALID(S_AXI_RVALID),
	.S_AXI_RREADY(S_AXI_RREADY)
);

`default_nettype wire

// File: tb/tb_fir_axi_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fir_axi_top;
	import fir_pkg::*;

	localparam int taps = 8;
	localparam int coef_mag = 17;
	localparam int data_width = 14;
	localparam int bypass_cycles = 100;
	localparam int filter_cycles = 150;
	localparam int impulse_cycles = 40;
	// rough count of AXI transactions and their worst length
	localparam int axi_ops = 30;
	localparam int axi_op_cycles = 20;
	localparam int total_cycles = 3 + axi_ops * axi_op_cycles
		+ bypass_cycles + filter_cycles + impulse_cycles;
	localparam int wait_limit = 50;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;
	logic [axi_addr_width-1:0] awaddr, araddr;
	logic awvalid, wvalid, bready, arvalid, rready;
	logic [axi_data_width-1:0] wdata;
	logic awready, wready, bvalid, arready, rvalid;
	logic [1:0] bresp, rresp;
	logic [axi_data_width-1:0] rdata;
	logic signed [data_width-1:0] fir_in, fir_out;
	logic [7:0] leds;

	int seed = 85;
	int err_count = 0;
	// stimulus history and testbench copy of the filter setup
	longint hist[$];
	longint coef_ref[taps];
	logic fir_en_ref = 1'b0;
	logic check_on = 1'b0;
	logic zero_mode = 1'b0;
	logic impulse_pending = 1'b0;
	int stable = 0;

	fir_axi_top #(.TAPS(taps), .DATA_WIDTH(data_width), .COEF_WIDTH(18), .COEF_MAG(coef_mag))
	fir_axi_top_i (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.S_AXI_AWADDR(awaddr), .S_AXI_AWPROT(3'b000), .S_AXI_AWVALID(awvalid),
		.S_AXI_AWREADY(awready), .S_AXI_WDATA(wdata), .S_AXI_WSTRB(4'hf),
		.S_AXI_WVALID(wvalid), .S_AXI_WREADY(wready), .S_AXI_BRESP(bresp),
		.S_AXI_BVALID(bvalid), .S_AXI_BREADY(bready), .S_AXI_ARADDR(araddr),
		.S_AXI_ARPROT(3'b000), .S_AXI_ARVALID(arvalid), .S_AXI_ARREADY(arready),
		.S_AXI_RDATA(rdata), .S_AXI_RRESP(rresp), .S_AXI_RVALID(rvalid),
		.S_AXI_RREADY(rready), .fir_in(fir_in), .fir_out(fir_out), .leds(leds)
	);

	always #20 S_AXI_ACLK = ~S_AXI_ACLK;

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			err_count++;
			$display("Fail %s got %h expected %h", name, got, exp);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic give_up(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1);
	endtask

	// sign bit from bit 31, magnitude field from the low bits
	function automatic longint decode_coef(input logic [31:0] w);
		longint mag;
		mag = longint'(w[16:0]);
		return w[31] ? mag - 131072 : mag;
	endfunction

	// expected output for the sample at position idx of the history
	function automatic logic [31:0] ref_out(input int idx);
		longint acc;
		logic [data_width-1:0] low;
		acc = 0;
		if (!fir_en_ref) begin
			low = hist[idx][data_width-1:0];
			return 32'(low);
		end
		for (int k = 0; k < taps; k++) begin
			if (idx - k >= 0) begin
				acc += coef_ref[k] * hist[idx-k];
			end
		end
		acc = acc >>> coef_mag;
		low = acc[data_width-1:0];
		return 32'(low);
	endfunction

	task automatic axi_write(input logic [15:0] addr, input logic [31:0] data, input int hold);
		int n;
		awaddr <= addr;
		wdata <= data;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		n = 0;
		do begin
			@(negedge S_AXI_ACLK);
			if (++n > wait_limit) give_up("write address was never accepted");
		end while (!(awready && wready));
		@(posedge S_AXI_ACLK);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		n = 0;
		do begin
			@(negedge S_AXI_ACLK);
			if (++n > wait_limit) give_up("write response never arrived");
		end while (!bvalid);
		// response must wait under back-pressure
		repeat (hold) begin
			@(negedge S_AXI_ACLK);
			check_value("S_AXI_BVALID", 32'(bvalid), 32'h1);
		end
		@(posedge S_AXI_ACLK);
		bready <= 1'b1;
		n = 0;
		do begin
			@(negedge S_AXI_ACLK);
			if (++n > wait_limit) give_up("write response was never released");
		end while (bvalid);
		@(posedge S_AXI_ACLK);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [15:0] addr, input int hold, output logic [31:0] data);
		int n;
		araddr <= addr;
		arvalid <= 1'b1;
		n = 0;
		do begin
			@(negedge S_AXI_ACLK);
			if (++n > wait_limit) give_up("read address was never accepted");
		end while (!arready);
		@(posedge S_AXI_ACLK);
		arvalid <= 1'b0;
		n = 0;
		do begin
			@(negedge S_AXI_ACLK);
			if (++n > wait_limit) give_up("read data never arrived");
		end while (!rvalid);
		data = rdata;
		repeat (hold) begin
			@(negedge S_AXI_ACLK);
			check_value("S_AXI_RVALID", 32'(rvalid), 32'h1);
			check_value("S_AXI_RDATA", rdata, data);
		end
		@(posedge S_AXI_ACLK);
		rready <= 1'b1;
		n = 0;
		do begin
			@(negedge S_AXI_ACLK);
			if (++n > wait_limit) give_up("read data was never released");
		end while (rvalid);
		@(posedge S_AXI_ACLK);
		rready <= 1'b0;
	endtask

	task automatic read_expect(input logic [15:0] addr, input logic [31:0] exp, input string name);
		logic [31:0] got;
		axi_read(addr, 0, got);
		check_value(name, got, exp);
	endtask

	// sample source, one new sample per clock
	always @(posedge S_AXI_ACLK) begin
		logic [31:0] r;
		r = $random(seed);
		if (impulse_pending) begin
			r = 32'd4096;
			impulse_pending = 1'b0;
		end else if (zero_mode) begin
			r = 32'd0;
		end
		fir_in <= r[data_width-1:0];
		hist.push_back(longint'($signed(r[data_width-1:0])));
	end

	// compares fir_out against the sample fir_latency clocks back
	always @(negedge S_AXI_ACLK) begin
		if (check_on) begin
			if (stable >= taps + fir_latency) begin
				check_value("fir_out", 32'(fir_out[data_width-1:0]),
					ref_out(hist.size() - 1 - fir_latency));
			end
			stable++;
		end
	end

	initial begin
		#(total_cycles * 40 + 4000);
		$display("Watchdog expired before the tests finished");
		$display("Some tests failed");
		$fatal(1);
	end

	initial begin
		logic [31:0] w;
		logic [31:0] got;
		logic [13:0] exp14;
		longint scaled;
		S_AXI_ACLK = 1'b0;
		S_AXI_ARESETN = 1'b0;
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b0;
		arvalid = 1'b0;
		rready = 1'b0;
		fir_in = '0;
		for (int k = 0; k < taps; k++) coef_ref[k] = 0;
		repeat (3) @(posedge S_AXI_ACLK);
		S_AXI_ARESETN <= 1'b1;

		// reset state and identification words
		@(negedge S_AXI_ACLK);
		check_value("S_AXI_AWREADY", 32'(awready), 32'h0);
		check_value("S_AXI_WREADY", 32'(wready), 32'h0);
		check_value("S_AXI_BVALID", 32'(bvalid), 32'h0);
		check_value("S_AXI_ARREADY", 32'(arready), 32'h0);
		check_value("S_AXI_RVALID", 32'(rvalid), 32'h0);
		check_value("leds", 32'(leds), 32'h0);
		@(posedge S_AXI_ACLK);
		read_expect(16'h0000, "_RIF", "reg_name");
		read_expect(16'h0004, 32'h00302e32, "reg_version");
		read_expect(16'h0010, taps, "reg_taps");
		read_expect(16'h0030, coef_mag, "reg_coef_mag");
		read_expect(16'h0040, 32'h1, "reg_coef_base");

		// switches readback, then an unmapped write
		axi_write(16'h0050, 32'hdead00a5, 4);
		read_expect(16'h0050, 32'hdead00a5, "reg_switches");
		check_value("leds", 32'(leds), 32'ha5);
		axi_write(16'h0104, 32'hffffffff, 0);
		read_expect(16'h0104, 32'h0, "unmapped");
		read_expect(16'h0050, 32'hdead00a5, "reg_switches");

		// bypass, bit 1 of a5 is clear
		stable = 0;
		check_on = 1'b1;
		repeat (bypass_cycles) @(posedge S_AXI_ACLK);
		check_on = 1'b0;

		// random coefficients through bank 1, odd taps get a negative sign
		for (int k = 0; k < taps; k++) begin
			// drawn off the edge, the sample source shares the seed
			@(negedge S_AXI_ACLK);
			w = $random(seed);
			w[31] = k[0];
			coef_ref[k] = decode_coef(w);
			@(posedge S_AXI_ACLK);
			axi_write(16'h0200 + 16'(4 * k), w, 0);
		end
		axi_write(16'h0050, 32'h2, 0);
		fir_en_ref = 1'b1;
		stable = 0;
		check_on = 1'b1;
		repeat (filter_cycles) @(posedge S_AXI_ACLK);

		// impulse reads out the coefficients in tap order
		@(negedge S_AXI_ACLK);
		zero_mode = 1'b1;
		repeat (taps + 5) @(posedge S_AXI_ACLK);
		@(negedge S_AXI_ACLK);
		impulse_pending = 1'b1;
		@(posedge S_AXI_ACLK);
		repeat (fir_latency) @(posedge S_AXI_ACLK);
		for (int k = 0; k < taps; k++) begin
			@(negedge S_AXI_ACLK);
			scaled = (coef_ref[k] * 4096) >>> coef_mag;
			exp14 = scaled[13:0];
			check_value("fir_out", 32'(fir_out[13:0]), 32'(exp14));
		end
		check_on = 1'b0;
		zero_mode = 1'b0;

		// back-pressure, second write waits for the first response
		@(posedge S_AXI_ACLK);
		awaddr <= 16'h0050;
		wdata <= 32'h12;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		do @(negedge S_AXI_ACLK); while (!awready);
		@(posedge S_AXI_ACLK);
		wdata <= 32'h36;
		do @(negedge S_AXI_ACLK); while (!bvalid);
		repeat (6) begin
			@(negedge S_AXI_ACLK);
			check_value("S_AXI_BVALID", 32'(bvalid), 32'h1);
			check_value("S_AXI_AWREADY", 32'(awready), 32'h0);
		end
		@(posedge S_AXI_ACLK);
		bready <= 1'b1;
		do @(negedge S_AXI_ACLK); while (!awready);
		@(posedge S_AXI_ACLK);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		do @(negedge S_AXI_ACLK); while (!bvalid);
		do @(negedge S_AXI_ACLK); while (bvalid);
		@(posedge S_AXI_ACLK);
		bready <= 1'b0;
		check_value("leds", 32'(leds), 32'h36);
		axi_read(16'h0050, 6, got);
		check_value("reg_switches", got, 32'h36);

		if (err_count == 0 && fir_axi_top_i.fir_axi_top_properties_i.fail_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
logic/fir_pkg.sv
logic/reg_bus_if.sv
logic/axi_lite_slave.sv
logic/fir_regs.sv
logic/fir_tap.sv
logic/fir_datapath.sv
logic/fir_axi_top.sv
tb/fir_axi_top_properties.sv
tb/tb_fir_axi_top.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_fir_axi_top \
	-f tb.f -o sim_tb || exit 1
./obj_dir/sim_tb | tee /dev/stderr | grep -q "All tests passed" && exit 0 || exit 1
